// File: Bender.yml
package:
  name: aes_stream

sources:
  - hw/aes_stream_pkg.sv
  - hw/block_fifo.sv
  - hw/aes_enc_core.sv
  - hw/aes_stream_ctrl.sv
  - hw/aes_stream_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/aes_stream_tb.sv

// File: aes_stream_top.f
hw/aes_stream_pkg.sv
hw/block_fifo.sv
hw/aes_enc_core.sv
hw/aes_stream_ctrl.sv
hw/aes_stream_top.sv
bench/tb_clock.sv
bench/aes_stream_tb.sv

// File: bench/aes_stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aes_stream_tb
	import aes_stream_pkg::*;
();

	localparam int num_jobs = 8;
	localparam key_t fips_key = 128'h000102030405060708090a0b0c0d0e0f;
	localparam blk_t fips_pt = 128'h00112233445566778899aabbccddeeff;
	localparam blk_t fips_ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	logic clk;
	logic reset;
	logic in_wr;
	blk_t in_data;
	logic in_full;
	cmd_t cmd;
	logic source_done;
	logic out_rd;
	blk_t out_data;
	logic out_empty;
	logic processing_done;

	// job table, even jobs ecb and odd jobs cbc
	int job_blocks [num_jobs] = '{6, 8, 3, 5, 2, 4, 24, 10};
	int job_gap [num_jobs] = '{0, 0, 0, 0, 0, 0, 0, 4};
	int job_pause [num_jobs] = '{0, 0, 0, 0, 0, 0, 3, 2};
	bit job_hold [num_jobs] = '{0, 0, 0, 0, 0, 0, 1, 0};

	blk_t exp_q [$];
	int cycles = 0;
	int cycle_limit = 0;

	tb_clock #(.period_ns(100)) clk_gen (.clk(clk));

	aes_stream_top aes_stream_top_inst (
		.clk(clk),
		.reset(reset),
		.in_wr(in_wr),
		.in_data(in_data),
		.in_full(in_full),
		.cmd(cmd),
		.source_done(source_done),
		.out_rd(out_rd),
		.out_data(out_data),
		.out_empty(out_empty),
		.processing_done(processing_done)
	);

	// ####################
	// failure reporting

	task automatic stop_failed();
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_error(input string why);
		$display("%0t: %s", $time, why);
		stop_failed();
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
			report_error("timeout, the DUT stopped making progress");
	end

	// ####################
	// reference model

	function automatic blk_t aes128_encrypt(input key_t key, input blk_t pt);
		blk_t s;
		key_t rk;
		s = pt ^ key;
		rk = key;
		for (int r = 1; r <= 10; r++) begin
			rk = next_round_key(rk, rcon_of(r[3:0]));
			s = shift_rows(sub_bytes(s));
			if (r < 10)
				s = mix_columns(s);
			s = s ^ rk;
		end
		return s;
	endfunction

	function automatic blk_t random_block();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// ####################
	// host side

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic push_entry(input blk_t d);
		while (in_full)
			next_cycle();
		in_data = d;
		in_wr = 1'b1;
		next_cycle();
		in_wr = 1'b0;
	endtask

	task automatic write_job(input cmd_t mode, input int nblk, input int gap_max);
		blk_t key_entry;
		blk_t entry;
		blk_t iv;
		blk_t ct;
		key_t key;
		key_entry = random_block();
		key = swap_bytes128(key_entry);
		iv = '0;
		cmd = mode; // sampled with the key entry
		source_done = 1'b0;
		push_entry(key_entry);
		while (processing_done)
			next_cycle(); // falls as the job starts
		if (mode == CMD_CBC_ENC) begin
			entry = random_block();
			iv = swap_bytes128(entry);
			push_entry(entry);
		end
		for (int i = 0; i < nblk; i++) begin
			repeat ($urandom_range(gap_max)) next_cycle();
			entry = random_block();
			if (mode == CMD_CBC_ENC) begin
				ct = aes128_encrypt(key, swap_bytes128(entry) ^ iv);
				iv = ct; // chain
			end else begin
				ct = aes128_encrypt(key, swap_bytes128(entry));
			end
			exp_q.push_back(swap_bytes128(ct));
			push_entry(entry);
			check_value("processing_done", processing_done, 0);
		end
		source_done = 1'b1;
		while (!processing_done)
			next_cycle();
	endtask

	task automatic read_job(input int nblk, input bit hold, input int pause_max);
		blk_t exp;
		if (hold) begin
			// let the output queue back up
			while (!aes_stream_top_inst.out_fifo_full)
				next_cycle();
		end
		for (int i = 0; i < nblk; i++) begin
			while (out_empty)
				next_cycle();
			out_rd = 1'b1;
			next_cycle();
			out_rd = 1'b0;
			if (exp_q.size() == 0)
				report_error("DUT produced a block that was never sent");
			exp = exp_q.pop_front();
			check_value("out_data", out_data, exp);
			repeat ($urandom_range(pause_max)) next_cycle();
		end
	endtask

	task automatic run_job(input cmd_t mode, input int nblk, input int gap_max,
			input bit hold, input int pause_max);
		fork
			write_job(mode, nblk, gap_max);
			read_job(nblk, hold, pause_max);
		join
		next_cycle();
		check_value("out_empty", out_empty, 1); // nothing duplicated
		check_value("processing_done", processing_done, 1);
	endtask

	// ####################
	// main sequence

	initial begin
		cmd_t mode;
		reset = 1'b1;
		in_wr = 1'b0;
		in_data = '0;
		cmd = CMD_ECB_ENC;
		source_done = 1'b0;
		out_rd = 1'b0;
		void'($urandom(32'h83d6dbae));

		cycle_limit = 20; // reset and slack
		for (int j = 0; j < num_jobs; j++)
			cycle_limit += job_blocks[j] * 20 + 50;

		check_value("model_ct", aes128_encrypt(fips_key, fips_pt), fips_ct);

		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		next_cycle();

		// queues empty and no job done out of reset
		check_value("in_full", in_full, 0);
		check_value("out_empty", out_empty, 1);
		check_value("processing_done", processing_done, 0);

		for (int j = 0; j < num_jobs; j++) begin
			mode = (j % 2 == 1) ? CMD_CBC_ENC : CMD_ECB_ENC;
			run_job(mode, job_blocks[j], job_gap[j], job_hold[j], job_pause[j]);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int period_ns = 100
) (
	output logic clk
);

	initial clk = 1'b0;
	always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: hw/aes_enc_core.sv
`timescale 1ns/1ps
`default_nettype none

module aes_enc_core
	import aes_stream_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  key_t key,
	input  blk_t block,
	output blk_t result,
	output logic done
);

	blk_t aes_state;
	key_t round_key;
	logic [3:0] round;
	logic busy;

	blk_t sr_out;
	blk_t mc_out;
	blk_t round_out;
	logic last_round;

	// ####################
	// one round of the cipher per clock

	assign last_round = (round == num_rounds);
	assign sr_out = shift_rows(sub_bytes(aes_state));
	assign mc_out = mix_columns(sr_out);
	assign round_out = (last_round ? sr_out : mc_out) ^ round_key; // no mixing in round 10

	assign result = aes_state;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			round <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				round <= 4'd1;
			end else if (busy) begin
				round <= round + 4'd1;
				if (last_round) begin
					busy <= 1'b0;
					done <= 1'b1; // lands with the final state
				end
			end
		end
	end

	// ####################
	// datapath and key schedule

	always_ff @(posedge clk) begin
		if (start) begin
			aes_state <= block ^ key; // round 0
			round_key <= next_round_key(key, rcon_of(4'd1));
		end else if (busy) begin
			aes_state <= round_out;
			// key for the next round derived on the fly
			round_key <= next_round_key(round_key, rcon_of(round + 4'd1));
		end
	end

endmodule

`default_nettype wire

// File: hw/aes_stream_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module aes_stream_ctrl
	import aes_stream_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  cmd_t cmd,
	input  logic source_done,

	// input queue
	input  blk_t in_fifo_data,
	input  logic in_fifo_empty,
	output logic in_fifo_rd,

	// output queue
	input  logic out_fifo_full,
	output blk_t out_fifo_data,
	output logic out_fifo_wr,

	// cipher core
	output logic core_start,
	output key_t core_key,
	output blk_t core_block,
	input  blk_t core_result,
	input  logic core_done,

	output logic processing_done
);

	typedef enum logic [2:0] {
		idle,
		get_key,
		get_iv,
		next_block,
		wait_core,
		store_block
	} state_t;

	state_t state;
	cmd_t cmd_q;
	key_t key_q;
	blk_t iv_q;
	blk_t plain;
	logic start_req;
	logic in_valid;
	logic is_cbc;
	logic in_can_rd;
	logic out_can_wr;

	assign is_cbc = (cmd_q == CMD_CBC_ENC); // anything else runs as ecb
	assign in_can_rd = !in_fifo_rd && !in_fifo_empty;
	assign out_can_wr = !out_fifo_wr && !out_fifo_full;

	// read data holds still while the core runs
	assign plain = swap_bytes128(in_fifo_data);
	assign core_block = is_cbc ? (plain ^ iv_q) : plain;
	assign core_key = key_q;

	// ####################
	// job FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			cmd_q <= '0;
			in_fifo_rd <= 1'b0;
			in_valid <= 1'b0;
			out_fifo_wr <= 1'b0;
			start_req <= 1'b0;
			core_start <= 1'b0;
			processing_done <= 1'b0;
		end else begin
			in_fifo_rd <= 1'b0;
			in_valid <= in_fifo_rd; // read data lands
			out_fifo_wr <= 1'b0;
			start_req <= 1'b0;
			core_start <= start_req; // wait for fifo read data

			case (state)
				idle: begin
					if (in_can_rd) begin
						in_fifo_rd <= 1'b1; // key entry
						cmd_q <= cmd;
						processing_done <= 1'b0;
						state <= get_key;
					end
				end
				get_key: begin
					if (in_valid) begin
						key_q <= swap_bytes128(in_fifo_data);
						state <= is_cbc ? get_iv : next_block;
					end
				end
				get_iv: begin
					if (in_valid) begin
						iv_q <= swap_bytes128(in_fifo_data);
						state <= next_block;
					end else if (in_can_rd) begin
						in_fifo_rd <= 1'b1;
					end
				end
				next_block: begin
					if (in_can_rd) begin
						in_fifo_rd <= 1'b1;
						start_req <= 1'b1;
						state <= wait_core;
					end else if (source_done && in_fifo_empty) begin
						processing_done <= 1'b1;
						state <= idle;
					end
				end
				wait_core: begin
					if (core_done) begin
						out_fifo_data <= swap_bytes128(core_result);
						if (is_cbc)
							iv_q <= core_result; // chain ciphertext
						state <= store_block;
					end
				end
				store_block: begin
					// held here while the output queue is full
					if (out_can_wr) begin
						out_fifo_wr <= 1'b1;
						state <= next_block;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/aes_stream_pkg.sv
`default_nettype none

package aes_stream_pkg;

	localparam int unsigned word_w = 32;
	localparam int unsigned blk_w = 128;
	localparam int unsigned num_rounds = 10;
	localparam int unsigned fifo_addr_w = 4; // 16-entry queues

	typedef logic [blk_w-1:0] blk_t;
	typedef logic [blk_w-1:0] key_t;
	typedef logic [word_w-1:0] cmd_t;

	localparam cmd_t CMD_ECB_ENC = 32'h0000_0001;
	localparam cmd_t CMD_CBC_ENC = 32'h0000_0002;

	// ####################
	// forward s-box, entry 0 leftmost
	localparam logic [0:255][7:0] sbox = {
		128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// ####################
	// round transforms, byte 0 in the top bits, state column major
	function automatic blk_t sub_bytes(input blk_t s);
		blk_t r;
		for (int i = 0; i < 16; i++)
			r[127-8*i -: 8] = sbox[s[127-8*i -: 8]];
		return r;
	endfunction

	function automatic blk_t shift_rows(input blk_t s);
		blk_t r;
		for (int c = 0; c < 4; c++)
			for (int row = 0; row < 4; row++)
				r[127-8*(row+4*c) -: 8] = s[127-8*(row+4*((c+row)%4)) -: 8];
		return r;
	endfunction

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic blk_t mix_columns(input blk_t s);
		blk_t r;
		logic [7:0] a0, a1, a2, a3;
		for (int c = 0; c < 4; c++) begin
			a0 = s[127-32*c -: 8];
			a1 = s[119-32*c -: 8];
			a2 = s[111-32*c -: 8];
			a3 = s[103-32*c -: 8];
			r[127-32*c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
			r[119-32*c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
			r[111-32*c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
			r[103-32*c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
		end
		return r;
	endfunction

	function automatic logic [7:0] rcon_of(input logic [3:0] round);
		case (round)
			4'd1: return 8'h01;
			4'd2: return 8'h02;
			4'd3: return 8'h04;
			4'd4: return 8'h08;
			4'd5: return 8'h10;
			4'd6: return 8'h20;
			4'd7: return 8'h40;
			4'd8: return 8'h80;
			4'd9: return 8'h1b;
			4'd10: return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

	function automatic key_t next_round_key(input key_t k, input logic [7:0] rc);
		logic [word_w-1:0] t, w0, w1, w2, w3;
		t = k[31:0];
		t = {sbox[t[23:16]], sbox[t[15:8]], sbox[t[7:0]], sbox[t[31:24]]} ^ {rc, 24'h0};
		w0 = k[127:96] ^ t;
		w1 = k[95:64] ^ w0;
		w2 = k[63:32] ^ w1;
		w3 = k[31:0] ^ w2;
		return {w0, w1, w2, w3};
	endfunction

	// host words arrive little endian per 32-bit word
	function automatic blk_t swap_bytes128(input blk_t d);
		blk_t r;
		for (int w = 0; w < blk_w / word_w; w++)
			for (int b = 0; b < word_w / 8; b++)
				r[w*word_w + b*8 +: 8] = d[w*word_w + (word_w/8 - 1 - b)*8 +: 8];
		return r;
	endfunction

endpackage

`default_nettype wire

// File: hw/aes_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module aes_stream_top
	import aes_stream_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic in_wr,
	input  blk_t in_data,
	output logic in_full,
	input  cmd_t cmd,
	input  logic source_done,
	input  logic out_rd,
	output blk_t out_data,
	output logic out_empty,
	output logic processing_done
);

	blk_t in_fifo_data;
	logic in_fifo_empty;
	logic in_fifo_rd;
	blk_t out_fifo_data;
	logic out_fifo_full;
	logic out_fifo_wr;

	logic core_start;
	key_t core_key;
	blk_t core_block;
	blk_t core_result;
	logic core_done;

	// ####################
	// queues

	block_fifo in_q (
		.clk(clk),
		.reset(reset),
		.wr(in_wr),
		.wr_data(in_data),
		.rd(in_fifo_rd),
		.rd_data(in_fifo_data),
		.empty(in_fifo_empty),
		.full(in_full)
	);

	block_fifo out_q (
		.clk(clk),
		.reset(reset),
		.wr(out_fifo_wr),
		.wr_data(out_fifo_data),
		.rd(out_rd),
		.rd_data(out_data),
		.empty(out_empty),
		.full(out_fifo_full)
	);

	// ####################
	// control and cipher

	aes_stream_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.source_done(source_done),
		.in_fifo_data(in_fifo_data),
		.in_fifo_empty(in_fifo_empty),
		.in_fifo_rd(in_fifo_rd),
		.out_fifo_full(out_fifo_full),
		.out_fifo_data(out_fifo_data),
		.out_fifo_wr(out_fifo_wr),
		.core_start(core_start),
		.core_key(core_key),
		.core_block(core_block),
		.core_result(core_result),
		.core_done(core_done),
		.processing_done(processing_done)
	);

	aes_enc_core u_core (
		.clk(clk),
		.reset(reset),
		.start(core_start),
		.key(core_key),
		.block(core_block),
		.result(core_result),
		.done(core_done)
	);

endmodule

`default_nettype wire

// File: hw/block_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module block_fifo
	import aes_stream_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic wr,
	input  blk_t wr_data,
	input  logic rd,
	output blk_t rd_data,
	output logic empty,
	output logic full
);

	blk_t mem [2**fifo_addr_w];
	logic [fifo_addr_w-1:0] wr_ptr;
	logic [fifo_addr_w-1:0] rd_ptr;
	logic [fifo_addr_w:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;
	assign empty = (count == '0);
	assign full = count[fifo_addr_w]; // count hit depth

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr]; // registered read port
	end

endmodule

`default_nettype wire
